// File: verilog.f
logic/vlsu_pkg.sv
logic/vlsu_rob_if.sv
logic/vlsu_addr_gen.sv
logic/vlsu_reorder_buffer.sv
logic/vlsu_vrf_writer.sv
logic/vlsu_top.sv
test/tb_vlsu.sv

// File: test/tb_vlsu.sv
module tb_vlsu;

  localparam int NUM_INSNS      = 60;
  localparam int MAX_CYCLES     = NUM_INSNS * 32 * 20;
  localparam int NR_OUTSTANDING = 4;
  localparam int ID_W           = $clog2(NR_OUTSTANDING);
  localparam int VLENB          = vlsu_pkg::VLENB;
  localparam int VRF_BYTES      = vlsu_pkg::NR_VREGS * VLENB;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic                req_valid_i;
  logic                req_ready_o;
  vlsu_pkg::vlsu_op_e  req_op_i;
  vlsu_pkg::vsew_e     req_vsew_i;
  vlsu_pkg::vl_t       req_vl_i;
  vlsu_pkg::word_t     req_base_i;
  vlsu_pkg::word_t     req_stride_i;
  vlsu_pkg::vreg_t     req_vd_i;
  vlsu_pkg::insn_id_t  req_id_i;
  logic                mem_req_valid_o;
  logic                mem_req_ready_i;
  vlsu_pkg::word_t     mem_req_addr_o;
  logic [ID_W-1:0]     mem_req_id_o;
  logic                mem_rsp_valid_i;
  logic [ID_W-1:0]     mem_rsp_id_i;
  vlsu_pkg::word_t     mem_rsp_data_i;
  logic                vrf_we_o;
  logic                vrf_wready_i;
  vlsu_pkg::vrf_addr_t vrf_waddr_o;
  vlsu_pkg::word_t     vrf_wdata_o;
  vlsu_pkg::be_t       vrf_wbe_o;
  logic                rsp_valid_o;
  vlsu_pkg::insn_id_t  rsp_id_o;

  vlsu_top #(.NrOutstanding(NR_OUTSTANDING)) i_dut (.*);

  always #5 clk_i = ~clk_i;

  // Instruction list
  vlsu_pkg::vlsu_op_e ins_op     [NUM_INSNS];
  vlsu_pkg::vsew_e    ins_vsew   [NUM_INSNS];
  vlsu_pkg::vl_t      ins_vl     [NUM_INSNS];
  vlsu_pkg::word_t    ins_base   [NUM_INSNS];
  vlsu_pkg::word_t    ins_stride [NUM_INSNS];
  vlsu_pkg::vreg_t    ins_vd     [NUM_INSNS];
  vlsu_pkg::insn_id_t ins_id     [NUM_INSNS];

  logic [31:0] rng_state;
  int value_errors;
  int other_errors;
  int cycle;
  int done_count;
  int next_insn;
  int cur_insn;
  int req_k;
  int bytes_done;
  logic req_taken;

  // Payload seen while a transfer was held
  logic                mem_hold;
  vlsu_pkg::word_t     mem_hold_addr;
  logic [ID_W-1:0]     mem_hold_id;
  logic                vrf_hold;
  vlsu_pkg::vrf_addr_t vrf_hold_addr;
  vlsu_pkg::word_t     vrf_hold_data;
  vlsu_pkg::be_t       vrf_hold_be;

  int              inflight [$];
  logic [ID_W-1:0] pend_id [$];
  vlsu_pkg::word_t pend_addr [$];
  logic [7:0]      vrf_model [VRF_BYTES];
  logic [7:0]      ref_vrf [VRF_BYTES];

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [7:0] mem_byte(vlsu_pkg::word_t a);
    return a[7:0] ^ 8'h5A;
  endfunction

  function automatic vlsu_pkg::word_t mem_word(vlsu_pkg::word_t wa);
    return {mem_byte(wa + 3), mem_byte(wa + 2), mem_byte(wa + 1), mem_byte(wa)};
  endfunction

  function automatic logic [7:0] vrf_fill(int b);
    return 8'(b) ^ 8'((b >> 8) * 8'h61);
  endfunction

  function automatic int insn_bytes(int n);
    return int'(ins_vl[n]) << int'(ins_vsew[n]);
  endfunction

  function automatic int req_count(int n);
    if (ins_op[n] == vlsu_pkg::OP_VLE) begin
      return (insn_bytes(n) + 3) / 4;
    end
    return int'(ins_vl[n]);
  endfunction

  function automatic vlsu_pkg::word_t expected_req_addr(int n, int k);
    if (ins_op[n] == vlsu_pkg::OP_VLE) begin
      return ins_base[n] + vlsu_pkg::word_t'(4 * k);
    end
    return (ins_base[n] + vlsu_pkg::word_t'(k) * ins_stride[n]) & ~vlsu_pkg::word_t'(3);
  endfunction

  //////////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////////

  task automatic gen_insns();
    int esize;
    int mult;
    for (int n = 0; n < NUM_INSNS; n++) begin
      // First six cover every opcode and width once
      if (n < 6) begin
        ins_op[n]   = vlsu_pkg::vlsu_op_e'(n % 2);
        ins_vsew[n] = vlsu_pkg::vsew_e'(n / 2);
      end else begin
        ins_op[n]   = vlsu_pkg::vlsu_op_e'(next_random() % 2);
        ins_vsew[n] = vlsu_pkg::vsew_e'(next_random() % 3);
      end
      esize      = 1 << int'(ins_vsew[n]);
      ins_vl[n]  = vlsu_pkg::vl_t'(1 + next_random() % (32 / esize));
      ins_base[n] = 32'h0000_4000 + (next_random() & 32'h0000_0fff);
      if (ins_op[n] == vlsu_pkg::OP_VLE) begin
        ins_base[n] = ins_base[n] & ~vlsu_pkg::word_t'(3);
      end else begin
        ins_base[n] = ins_base[n] & ~vlsu_pkg::word_t'(esize - 1);
      end
      mult = 1 + next_random() % 4;
      ins_stride[n] = vlsu_pkg::word_t'(mult * esize);
      if ((next_random() % 2) == 1) begin
        ins_stride[n] = -ins_stride[n];
      end
      ins_vd[n] = vlsu_pkg::vreg_t'(next_random() % 32);
      ins_id[n] = vlsu_pkg::insn_id_t'(next_random() % 8);
    end
  endtask

  task automatic present_insn(int n);
    req_valid_i  = 1'b1;
    req_op_i     = ins_op[n];
    req_vsew_i   = ins_vsew[n];
    req_vl_i     = ins_vl[n];
    req_base_i   = ins_base[n];
    req_stride_i = ins_stride[n];
    req_vd_i     = ins_vd[n];
    req_id_i     = ins_id[n];
  endtask

  // Runs on the falling edge
  task automatic drive_inputs();
    int idx;
    mem_req_ready_i = (next_random() % 4) != 0;
    vrf_wready_i    = (next_random() % 4) != 0;
    mem_rsp_valid_i = 1'b0;
    // Answer any pending request, not necessarily the oldest
    if (pend_id.size() > 0 && (next_random() % 2) == 0) begin
      idx = next_random() % pend_id.size();
      mem_rsp_valid_i = 1'b1;
      mem_rsp_id_i    = pend_id[idx];
      mem_rsp_data_i  = mem_word(pend_addr[idx]);
      pend_id.delete(idx);
      pend_addr.delete(idx);
    end
    if (req_taken) begin
      req_valid_i = 1'b0;
      req_taken   = 1'b0;
    end
    if (!req_valid_i && next_insn < NUM_INSNS && (next_random() % 4) != 0) begin
      present_insn(next_insn);
      next_insn++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////////////////////////////////

  task automatic apply_ref(int n);
    int vbase;
    int esize;
    vbase = int'(ins_vd[n]) * VLENB;
    esize = 1 << int'(ins_vsew[n]);
    if (ins_op[n] == vlsu_pkg::OP_VLE) begin
      for (int j = 0; j < insn_bytes(n); j++) begin
        ref_vrf[vbase + j] = mem_byte(ins_base[n] + vlsu_pkg::word_t'(j));
      end
    end else begin
      for (int i = 0; i < int'(ins_vl[n]); i++) begin
        for (int b = 0; b < esize; b++) begin
          ref_vrf[vbase + i * esize + b] = mem_byte(ins_base[n]
              + vlsu_pkg::word_t'(i) * ins_stride[n] + vlsu_pkg::word_t'(b));
        end
      end
    end
  endtask

  // Whole register, so bytes past vl must be untouched too
  task automatic check_vd(int n);
    int vbase;
    vbase = int'(ins_vd[n]) * VLENB;
    for (int b = 0; b < VLENB; b++) begin
      assert (vrf_model[vbase + b] === ref_vrf[vbase + b]) else begin
        $display("error %0t vrf v%0d byte %0d expected %h actual %h", $time, ins_vd[n], b,
                 ref_vrf[vbase + b], vrf_model[vbase + b]);
        value_errors++;
      end
    end
  endtask

  task automatic check_holds();
    if (mem_hold) begin
      assert (mem_req_valid_o && mem_req_addr_o == mem_hold_addr
              && mem_req_id_o == mem_hold_id) else begin
        $display("Held memory request changed or dropped at %0t", $time);
        other_errors++;
      end
    end
    if (vrf_hold) begin
      assert (vrf_we_o && vrf_waddr_o == vrf_hold_addr && vrf_wdata_o == vrf_hold_data
              && vrf_wbe_o == vrf_hold_be) else begin
        $display("Held VRF write changed or dropped at %0t", $time);
        other_errors++;
      end
    end
    mem_hold      = mem_req_valid_o && !mem_req_ready_i;
    mem_hold_addr = mem_req_addr_o;
    mem_hold_id   = mem_req_id_o;
    vrf_hold      = vrf_we_o && !vrf_wready_i;
    vrf_hold_addr = vrf_waddr_o;
    vrf_hold_data = vrf_wdata_o;
    vrf_hold_be   = vrf_wbe_o;
  endtask

  task automatic check_vrf_write();
    int n;
    int pos;
    vlsu_pkg::be_t allowed;
    assert (inflight.size() > 0) else begin
      $display("VRF write at %0t with no instruction outstanding", $time);
      other_errors++;
    end
    if (inflight.size() > 0) begin
      n = inflight[0];
      allowed = '0;
      for (int j = 0; j < 4; j++) begin
        pos = (int'(vrf_waddr_o) % vlsu_pkg::WORDS_PER_VREG) * 4 + j;
        allowed[j] = pos < insn_bytes(n);
      end
      assert (int'(vrf_waddr_o) / vlsu_pkg::WORDS_PER_VREG == int'(ins_vd[n])) else begin
        $display("error %0t vrf_waddr_o expected register %0d actual %0d", $time, ins_vd[n],
                 int'(vrf_waddr_o) / vlsu_pkg::WORDS_PER_VREG);
        value_errors++;
      end
      assert ((vrf_wbe_o & ~allowed) == '0) else begin
        $display("error %0t vrf_wbe_o expected within %b actual %b", $time, allowed,
                 vrf_wbe_o);
        value_errors++;
      end
      for (int j = 0; j < 4; j++) begin
        if (vrf_wbe_o[j]) begin
          vrf_model[int'(vrf_waddr_o) * 4 + j] = vrf_wdata_o[8*j +: 8];
          bytes_done++;
        end
      end
    end
  endtask

  // Runs on the rising edge, before the DUT registers update
  task automatic observe_cycle();
    int n;
    cycle++;
    check_holds();
    if (mem_req_valid_o && mem_req_ready_i) begin
      assert (cur_insn >= 0 && req_k < req_count(cur_insn)) else begin
        $display("Memory request at %0t beyond what the instruction needs", $time);
        other_errors++;
      end
      assert (cur_insn < 0 || mem_req_addr_o == expected_req_addr(cur_insn, req_k)) else begin
        $display("error %0t mem_req_addr_o expected %h actual %h", $time,
                 expected_req_addr(cur_insn, req_k), mem_req_addr_o);
        value_errors++;
      end
      pend_id.push_back(mem_req_id_o);
      pend_addr.push_back(mem_req_addr_o);
      req_k++;
    end
    if (vrf_we_o && vrf_wready_i) begin
      check_vrf_write();
    end
    if (rsp_valid_o) begin
      assert (inflight.size() > 0) else begin
        $display("Instruction response at %0t with nothing outstanding", $time);
        other_errors++;
      end
      if (inflight.size() > 0) begin
        n = inflight.pop_front();
        assert (rsp_id_o == ins_id[n]) else begin
          $display("error %0t rsp_id_o expected %0d actual %0d", $time, ins_id[n], rsp_id_o);
          value_errors++;
        end
        assert (bytes_done == insn_bytes(n)) else begin
          $display("error %0t written bytes expected %0d actual %0d", $time, insn_bytes(n),
                   bytes_done);
          value_errors++;
        end
        apply_ref(n);
        check_vd(n);
        bytes_done = 0;
        done_count++;
      end
    end
    if (req_valid_i && req_ready_o) begin
      assert (cur_insn < 0 || req_k == req_count(cur_insn)) else begin
        $display("error %0t memory request count expected %0d actual %0d", $time,
                 req_count(cur_insn), req_k);
        value_errors++;
      end
      cur_insn = next_insn - 1;
      inflight.push_back(cur_insn);
      req_k     = 0;
      req_taken = 1'b1;
    end
  endtask

  initial begin
    rng_state    = 32'd72090;
    value_errors = 0;
    other_errors = 0;
    cycle        = 0;
    done_count   = 0;
    next_insn    = 0;
    cur_insn     = -1;
    req_k        = 0;
    bytes_done   = 0;
    req_taken    = 1'b0;
    mem_hold     = 1'b0;
    vrf_hold     = 1'b0;

    rst_n_i         = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = vlsu_pkg::OP_VLE;
    req_vsew_i      = vlsu_pkg::EW_8;
    req_vl_i        = '0;
    req_base_i      = '0;
    req_stride_i    = '0;
    req_vd_i        = '0;
    req_id_i        = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_id_i    = '0;
    mem_rsp_data_i  = '0;
    vrf_wready_i    = 1'b0;

    for (int b = 0; b < VRF_BYTES; b++) begin
      vrf_model[b] = vrf_fill(b);
      ref_vrf[b]   = vrf_fill(b);
    end
    gen_insns();

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    assert (req_ready_o === 1'b1 && mem_req_valid_o === 1'b0 && vrf_we_o === 1'b0
            && rsp_valid_o === 1'b0) else begin
      $display("error %0t reset outputs expected 1000 actual %b%b%b%b", $time, req_ready_o,
               mem_req_valid_o, vrf_we_o, rsp_valid_o);
      value_errors++;
    end

    while (done_count < NUM_INSNS && cycle < MAX_CYCLES) begin
      drive_inputs();
      @(posedge clk_i);
      observe_cycle();
      @(negedge clk_i);
    end

    if (done_count < NUM_INSNS) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions finished", cycle,
               done_count, NUM_INSNS);
      other_errors++;
    end

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: logic/vlsu_top.sv
module vlsu_top #(
  parameter  int unsigned NrOutstanding = 4,
  localparam int unsigned IdWidth       = $clog2(NrOutstanding)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Instruction request
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  vlsu_pkg::vlsu_op_e  req_op_i,
  input  vlsu_pkg::vsew_e     req_vsew_i,
  input  vlsu_pkg::vl_t       req_vl_i,
  input  vlsu_pkg::word_t     req_base_i,
  input  vlsu_pkg::word_t     req_stride_i,
  input  vlsu_pkg::vreg_t     req_vd_i,
  input  vlsu_pkg::insn_id_t  req_id_i,
  // Memory request
  output logic                mem_req_valid_o,
  input  logic                mem_req_ready_i,
  output vlsu_pkg::word_t     mem_req_addr_o,
  output logic [IdWidth-1:0]  mem_req_id_o,
  // Memory response
  input  logic                mem_rsp_valid_i,
  input  logic [IdWidth-1:0]  mem_rsp_id_i,
  input  vlsu_pkg::word_t     mem_rsp_data_i,
  // VRF write
  output logic                vrf_we_o,
  input  logic                vrf_wready_i,
  output vlsu_pkg::vrf_addr_t vrf_waddr_o,
  output vlsu_pkg::word_t     vrf_wdata_o,
  output vlsu_pkg::be_t       vrf_wbe_o,
  // Instruction response
  output logic                rsp_valid_o,
  output vlsu_pkg::insn_id_t  rsp_id_o
);

  rob_alloc_if #(.NrOutstanding(NrOutstanding)) alloc_if ();
  rob_read_if  #(.NrOutstanding(NrOutstanding)) read_if ();

  vlsu_addr_gen #(
    .NrOutstanding(NrOutstanding)
  ) i_addr_gen (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_op_i       (req_op_i),
    .req_vsew_i     (req_vsew_i),
    .req_vl_i       (req_vl_i),
    .req_base_i     (req_base_i),
    .req_stride_i   (req_stride_i),
    .req_vd_i       (req_vd_i),
    .req_id_i       (req_id_i),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_req_addr_o (mem_req_addr_o),
    .mem_req_id_o   (mem_req_id_o),
    .alloc          (alloc_if.producer)
  );

  vlsu_reorder_buffer #(
    .NrOutstanding(NrOutstanding)
  ) i_rob (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_id_i   (mem_rsp_id_i),
    .mem_rsp_data_i (mem_rsp_data_i),
    .alloc          (alloc_if.buffer),
    .rd             (read_if.buffer)
  );

  vlsu_vrf_writer #(
    .NrOutstanding(NrOutstanding)
  ) i_vrf_writer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .vrf_we_o    (vrf_we_o),
    .vrf_wready_i(vrf_wready_i),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_id_o    (rsp_id_o),
    .rd          (read_if.consumer)
  );

endmodule

// File: logic/vlsu_vrf_writer.sv
module vlsu_vrf_writer #(
  parameter  int unsigned NrOutstanding = 4,
  localparam int unsigned IdWidth       = $clog2(NrOutstanding)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // VRF write port
  output logic                vrf_we_o,
  input  logic                vrf_wready_i,
  output vlsu_pkg::vrf_addr_t vrf_waddr_o,
  output vlsu_pkg::word_t     vrf_wdata_o,
  output vlsu_pkg::be_t       vrf_wbe_o,
  // Instruction response
  output logic                rsp_valid_o,
  output vlsu_pkg::insn_id_t  rsp_id_o,
  // Head of the reorder buffer
  rob_read_if.consumer        rd
);

  function automatic vlsu_pkg::word_t rot_right(vlsu_pkg::word_t d, vlsu_pkg::offs_t b);
    logic [2*vlsu_pkg::ELEN-1:0] dd;
    dd = {d, d} >> (b * 8);
    return dd[vlsu_pkg::ELEN-1:0];
  endfunction

  function automatic vlsu_pkg::word_t rot_left(vlsu_pkg::word_t d, vlsu_pkg::offs_t b);
    logic [2*vlsu_pkg::ELEN-1:0] dd;
    dd = {d, d} << (b * 8);
    return dd[2*vlsu_pkg::ELEN-1:vlsu_pkg::ELEN];
  endfunction

  function automatic vlsu_pkg::be_t elem_mask(vlsu_pkg::vsew_e sew);
    unique case (sew)
      vlsu_pkg::EW_8:  return 4'b0001;
      vlsu_pkg::EW_16: return 4'b0011;
      default:         return 4'b1111;
    endcase
  endfunction

  vlsu_pkg::word_t aligned;
  vlsu_pkg::be_t   wbe;

  logic                we_q;
  vlsu_pkg::vrf_addr_t waddr_q;
  vlsu_pkg::word_t     wdata_q;
  vlsu_pkg::be_t       wbe_q;
  logic                last_q;
  vlsu_pkg::insn_id_t  id_q;

  ////////////////////////////////////////////////////////////////////////////
  // Realignment
  ////////////////////////////////////////////////////////////////////////////

  // Drop the memory offset first, then move to the VRF lane
  assign aligned = rot_left(rot_right(rd.head_data, rd.offset), rd.lane);

  always_comb begin
    if (rd.op == vlsu_pkg::OP_VLE) begin
      // Enable the leading bytes and the full word for a zero count
      wbe = (rd.nbytes == '0) ? '1 : vlsu_pkg::be_t'((5'd1 << rd.nbytes) - 5'd1);
    end else begin
      wbe = vlsu_pkg::be_t'(elem_mask(rd.vsew) << rd.lane);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write register
  ////////////////////////////////////////////////////////////////////////////

  // Take the next head when the register is empty or drains this cycle
  assign rd.pop = rd.head_valid && (!we_q || vrf_wready_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      we_q <= 1'b0;
    end else if (rd.pop) begin
      we_q <= 1'b1;
    end else if (vrf_wready_i) begin
      we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd.pop) begin
      waddr_q <= rd.vrf_addr;
      wdata_q <= aligned;
      wbe_q   <= wbe;
      last_q  <= rd.last;
      id_q    <= rd.insn_id;
    end
  end

  assign vrf_we_o    = we_q;
  assign vrf_waddr_o = waddr_q;
  assign vrf_wdata_o = wdata_q;
  assign vrf_wbe_o   = wbe_q;

  // Instruction done when its last entry lands in the VRF
  assign rsp_valid_o = we_q && vrf_wready_i && last_q;
  assign rsp_id_o    = id_q;

  vrf_write_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vrf_we_o && !vrf_wready_i |=>
      vrf_we_o && $stable(vrf_waddr_o) && $stable(vrf_wdata_o) && $stable(vrf_wbe_o));

endmodule

// File: logic/vlsu_reorder_buffer.sv
module vlsu_reorder_buffer #(
  parameter  int unsigned NrOutstanding = 4,
  localparam int unsigned IdWidth       = $clog2(NrOutstanding)
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Memory response, always accepted
  input  logic               mem_rsp_valid_i,
  input  logic [IdWidth-1:0] mem_rsp_id_i,
  input  vlsu_pkg::word_t    mem_rsp_data_i,
  // Producer and consumer sides
  rob_alloc_if.buffer        alloc,
  rob_read_if.buffer         rd
);

  typedef logic [IdWidth-1:0] id_t;

  // What the writer needs to commit one entry
  typedef struct packed {
    vlsu_pkg::vrf_addr_t vrf_addr;
    vlsu_pkg::offs_t     lane;
    vlsu_pkg::offs_t     offset;
    vlsu_pkg::vsew_e     vsew;
    vlsu_pkg::vlsu_op_e  op;
    vlsu_pkg::offs_t     nbytes;
    logic                last;
    vlsu_pkg::insn_id_t  insn_id;
  } entry_t;

  logic [NrOutstanding-1:0] busy_q;
  logic [NrOutstanding-1:0] filled_q;

  // Allocation and commit both run in order
  id_t wptr_q;
  id_t rptr_q;

  vlsu_pkg::word_t data_q [NrOutstanding];
  entry_t          info_q [NrOutstanding];
  entry_t          head;

  ////////////////////////////////////////////////////////////////////////////
  // Entry state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= '0;
      filled_q <= '0;
      wptr_q   <= '0;
      rptr_q   <= '0;
    end else begin
      if (alloc.alloc) begin
        busy_q[wptr_q] <= 1'b1;
        wptr_q         <= wptr_q + 1'b1;
      end
      if (mem_rsp_valid_i) begin
        filled_q[mem_rsp_id_i] <= 1'b1;
      end
      // Pop never hits the entry being allocated or filled
      if (rd.pop) begin
        busy_q[rptr_q]   <= 1'b0;
        filled_q[rptr_q] <= 1'b0;
        rptr_q           <= rptr_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (alloc.alloc) begin
      info_q[wptr_q] <= '{
        vrf_addr: alloc.vrf_addr,
        lane:     alloc.lane,
        offset:   alloc.offset,
        vsew:     alloc.vsew,
        op:       alloc.op,
        nbytes:   alloc.nbytes,
        last:     alloc.last,
        insn_id:  alloc.insn_id
      };
    end
    if (mem_rsp_valid_i) begin
      data_q[mem_rsp_id_i] <= mem_rsp_data_i;
    end
  end

  // Next free slot is still busy once all entries are out
  assign alloc.full    = busy_q[wptr_q];
  assign alloc.free_id = wptr_q;

  assign head = info_q[rptr_q];

  assign rd.head_valid = busy_q[rptr_q] && filled_q[rptr_q];
  assign rd.head_id    = rptr_q;
  assign rd.head_data  = data_q[rptr_q];
  assign rd.vrf_addr   = head.vrf_addr;
  assign rd.lane       = head.lane;
  assign rd.offset     = head.offset;
  assign rd.vsew       = head.vsew;
  assign rd.op         = head.op;
  assign rd.nbytes     = head.nbytes;
  assign rd.last       = head.last;
  assign rd.insn_id    = head.insn_id;

  // Memory only answers requests that are outstanding, and each only once
  rsp_hits_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_valid_i |-> busy_q[mem_rsp_id_i] && !filled_q[mem_rsp_id_i]);

endmodule

// File: logic/vlsu_addr_gen.sv
module vlsu_addr_gen #(
  parameter  int unsigned NrOutstanding = 4,
  localparam int unsigned IdWidth       = $clog2(NrOutstanding)
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Instruction request
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vlsu_pkg::vlsu_op_e req_op_i,
  input  vlsu_pkg::vsew_e    req_vsew_i,
  input  vlsu_pkg::vl_t      req_vl_i,
  input  vlsu_pkg::word_t    req_base_i,
  input  vlsu_pkg::word_t    req_stride_i,
  input  vlsu_pkg::vreg_t    req_vd_i,
  input  vlsu_pkg::insn_id_t req_id_i,
  // Memory request
  output logic               mem_req_valid_o,
  input  logic               mem_req_ready_i,
  output vlsu_pkg::word_t    mem_req_addr_o,
  output logic [IdWidth-1:0] mem_req_id_o,
  // Reorder buffer allocation
  rob_alloc_if.producer      alloc
);

  typedef enum logic {
    ST_IDLE,
    ST_ISSUE
  } state_e;

  // Wide enough for a full register of bytes
  typedef logic [7:0] nbytes_t;

  state_e state_q;

  vlsu_pkg::vlsu_op_e op_q;
  vlsu_pkg::vsew_e    vsew_q;
  vlsu_pkg::vreg_t    vd_q;
  vlsu_pkg::insn_id_t id_q;
  vlsu_pkg::word_t    stride_q;
  vlsu_pkg::word_t    addr_q;   // byte address of the current access
  nbytes_t            bpos_q;   // byte position inside vd
  nbytes_t            rem_q;    // bytes not yet requested

  logic    accept;
  logic    issue;
  logic    last_req;
  nbytes_t step;

  assign accept = req_valid_i && req_ready_o;
  assign issue  = mem_req_valid_o && mem_req_ready_i;

  // Unit-stride walks whole words, strided walks single elements
  assign step     = (op_q == vlsu_pkg::OP_VLE) ? nbytes_t'(vlsu_pkg::ELENB)
                                               : nbytes_t'(1) << vsew_q;
  assign last_req = rem_q <= step;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (issue && last_req) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction register and walk counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= req_op_i;
      vsew_q   <= req_vsew_i;
      vd_q     <= req_vd_i;
      id_q     <= req_id_i;
      stride_q <= req_stride_i;
      addr_q   <= req_base_i;
      bpos_q   <= '0;
      // vl counts elements, turn it into bytes
      rem_q    <= nbytes_t'(req_vl_i) << req_vsew_i;
    end else if (issue) begin
      addr_q <= addr_q + ((op_q == vlsu_pkg::OP_VLE) ? vlsu_pkg::word_t'(vlsu_pkg::ELENB)
                                                     : stride_q);
      bpos_q <= bpos_q + step;
      rem_q  <= rem_q - step;
    end
  end

  assign req_ready_o = (state_q == ST_IDLE);

  // Withheld while the buffer has no free entry
  assign mem_req_valid_o = (state_q == ST_ISSUE) && !alloc.full;
  assign mem_req_addr_o  = addr_q & ~vlsu_pkg::word_t'(vlsu_pkg::ELENB - 1);
  assign mem_req_id_o    = alloc.free_id;

  assign alloc.alloc    = issue;
  assign alloc.vrf_addr = vlsu_pkg::vrf_addr_t'(vd_q * vlsu_pkg::WORDS_PER_VREG
                                                + bpos_q / vlsu_pkg::ELENB);
  assign alloc.lane     = vlsu_pkg::offs_t'(bpos_q);
  assign alloc.offset   = vlsu_pkg::offs_t'(addr_q);
  assign alloc.vsew     = vsew_q;
  assign alloc.op       = op_q;
  // Partial count only on the tail word of a unit-stride load
  assign alloc.nbytes   = (op_q == vlsu_pkg::OP_VLE && last_req) ? vlsu_pkg::offs_t'(rem_q)
                                                                 : '0;
  assign alloc.last     = last_req;
  assign alloc.insn_id  = id_q;

  // A held memory request must not change under the slave
  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=>
      mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_id_o));

endmodule

// File: logic/vlsu_rob_if.sv
// Allocation side of the reorder buffer
interface rob_alloc_if #(
  parameter int unsigned NrOutstanding = 4
);

  localparam int unsigned IdWidth = $clog2(NrOutstanding);

  logic                alloc;
  vlsu_pkg::vrf_addr_t vrf_addr;
  vlsu_pkg::offs_t     lane;
  vlsu_pkg::offs_t     offset;
  vlsu_pkg::vsew_e     vsew;
  vlsu_pkg::vlsu_op_e  op;
  // Unit-stride byte count, zero is a full word
  vlsu_pkg::offs_t     nbytes;
  logic                last;
  vlsu_pkg::insn_id_t  insn_id;
  logic                full;
  logic [IdWidth-1:0]  free_id;

  modport producer (
    output alloc, vrf_addr, lane, offset, vsew, op, nbytes, last, insn_id,
    input  full, free_id
  );

  modport buffer (
    input  alloc, vrf_addr, lane, offset, vsew, op, nbytes, last, insn_id,
    output full, free_id
  );

endinterface

// Head of the reorder buffer towards the VRF writer
interface rob_read_if #(
  parameter int unsigned NrOutstanding = 4
);

  localparam int unsigned IdWidth = $clog2(NrOutstanding);

  logic                head_valid;
  logic [IdWidth-1:0]  head_id;
  vlsu_pkg::word_t     head_data;
  vlsu_pkg::vrf_addr_t vrf_addr;
  vlsu_pkg::offs_t     lane;
  vlsu_pkg::offs_t     offset;
  vlsu_pkg::vsew_e     vsew;
  vlsu_pkg::vlsu_op_e  op;
  vlsu_pkg::offs_t     nbytes;
  logic                last;
  vlsu_pkg::insn_id_t  insn_id;
  logic                pop;

  modport buffer (
    output head_valid, head_id, head_data, vrf_addr, lane, offset, vsew, op, nbytes,
    output last, insn_id,
    input  pop
  );

  modport consumer (
    input  head_valid, head_id, head_data, vrf_addr, lane, offset, vsew, op, nbytes,
    input  last, insn_id,
    output pop
  );

endinterface

// File: logic/vlsu_pkg.sv
package vlsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word and register geometry
  ////////////////////////////////////////////////////////////////////////////

  // Memory and VRF words share one width
  localparam int unsigned ELEN  = 32;
  localparam int unsigned ELENB = ELEN / 8;

  // One vector register is VLENB bytes wide
  localparam int unsigned VLENB          = 32;
  localparam int unsigned WORDS_PER_VREG = VLENB / ELENB;
  localparam int unsigned NR_VREGS       = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'b00,
    EW_16 = 2'b01,
    EW_32 = 2'b10
  } vsew_e;

  typedef enum logic {
    OP_VLE  = 1'b0,
    OP_VLSE = 1'b1
  } vlsu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Common types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;

  // Element count, 0 up to one register of bytes
  typedef logic [$clog2(VLENB):0] vl_t;

  // Register number times WORDS_PER_VREG plus word index
  typedef logic [$clog2(NR_VREGS*WORDS_PER_VREG)-1:0] vrf_addr_t;

  typedef logic [ELEN-1:0] word_t;
  typedef logic [ELENB-1:0] be_t;

  // Byte position inside one word
  typedef logic [$clog2(ELENB)-1:0] offs_t;

  typedef logic [2:0] insn_id_t;

endpackage
